// File: compile.f
+incdir+hdl
hdl/raster_pkg.sv
hdl/tri_queue.sv
hdl/tri_bbox.sv
hdl/area_reciprocal.sv
hdl/tri_setup.sv
hdl/raster_frontend.sv
test/tb_raster_frontend.sv

// File: hdl/area_reciprocal.sv
`include "raster_settings.svh"

module area_reciprocal (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      i_start,
    input  logic signed [`EDGE_W-1:0] i_area,
    output logic                      o_busy,
    output logic                      o_done,
    output logic [`RECIP_W-1:0]       o_recip
);

    localparam int CNT_W = $clog2(`RECIP_W);

    logic [`EDGE_W-1:0]  divisor;
    logic [`EDGE_W-1:0]  remainder;
    logic [`RECIP_W-1:0] quotient;
    logic [CNT_W-1:0]    bit_cnt;
    logic [`EDGE_W:0]    shifted;
    logic [`EDGE_W:0]    trial;
    logic                load;

    assign load = i_start && !o_busy;

    // Dividend bits leave the top of the quotient register as quotient bits enter below
    assign shifted = {remainder, quotient[`RECIP_W-1]};
    assign trial   = shifted - {1'b0, divisor};

    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_busy  <= 1'b0;
            o_done  <= 1'b0;
            bit_cnt <= '0;
        end else begin
            o_done <= 1'b0;
            if (load) begin
                o_busy  <= 1'b1;
                bit_cnt <= CNT_W'(`RECIP_W - 1);
            end else if (o_busy) begin
                bit_cnt <= bit_cnt - 1'b1;
                // Last quotient bit
                if (bit_cnt == '0) begin
                    o_busy <= 1'b0;
                    o_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            divisor   <= $unsigned(i_area);
            remainder <= '0;
            quotient  <= `RECIP_W'(1) << `RECIP_FRAC;
        end else if (o_busy) begin
            // Negative trial means restore
            if (trial[`EDGE_W]) begin
                remainder <= shifted[`EDGE_W-1:0];
                quotient  <= {quotient[`RECIP_W-2:0], 1'b0};
            end else begin
                remainder <= trial[`EDGE_W-1:0];
                quotient  <= {quotient[`RECIP_W-2:0], 1'b1};
            end
        end
    end

    assign o_recip = quotient;

    // Setup only starts an idle divider, and only for front-facing triangles
    assert property (@(posedge clk) disable iff (!rstn)
        i_start |-> !o_busy && (i_area > 0));

    // Done is set on the edge RECIP_W cycles after the start edge and seen one edge later
    assert property (@(posedge clk) disable iff (!rstn)
        load |-> ##(`RECIP_W + 1) o_done);

endmodule

// File: hdl/raster_frontend.sv
`include "raster_settings.svh"

module raster_frontend (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  i_tri_valid,
    output logic                  o_tri_ready,
    input  raster_pkg::triangle_t i_tri,
    output logic                  o_setup_valid,
    input  logic                  i_setup_ready,
    output raster_pkg::setup_t    o_setup
);

    raster_pkg::triangle_t q_tri;
    logic                  q_valid;
    logic                  q_ready;

    tri_queue tri_queue_inst (
        .clk     (clk),
        .rstn    (rstn),
        .i_valid (i_tri_valid),
        .o_ready (o_tri_ready),
        .i_tri   (i_tri),
        .o_valid (q_valid),
        .i_ready (q_ready),
        .o_tri   (q_tri)
    );

    tri_setup tri_setup_inst (
        .clk     (clk),
        .rstn    (rstn),
        .i_valid (q_valid),
        .o_ready (q_ready),
        .i_tri   (q_tri),
        .o_valid (o_setup_valid),
        .i_ready (i_setup_ready),
        .o_setup (o_setup)
    );

endmodule

// File: hdl/raster_pkg.sv
`include "raster_settings.svh"

package raster_pkg;

    typedef struct packed {
        logic signed [`COORD_W-1:0] x;
        logic signed [`COORD_W-1:0] y;
    } vertex_t;

    // Counter-clockwise winding gives a positive area
    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } triangle_t;

    typedef struct packed {
        logic signed [`COORD_W-1:0] min_x;
        logic signed [`COORD_W-1:0] min_y;
        logic signed [`COORD_W-1:0] max_x;
        logic signed [`COORD_W-1:0] max_y;
    } bbox_t;

    // Edge function at the box corner plus its per-pixel steps
    typedef struct packed {
        logic signed [`EDGE_W-1:0] value;
        logic signed [`EDGE_W-1:0] dx;
        logic signed [`EDGE_W-1:0] dy;
    } edge_t;

    typedef struct packed {
        bbox_t                     box;
        edge_t                     e0;
        edge_t                     e1;
        edge_t                     e2;
        logic signed [`EDGE_W-1:0] area;
        logic [`RECIP_W-1:0]       area_inv;
    } setup_t;

endpackage

// File: hdl/raster_settings.svh
`ifndef RASTER_SETTINGS_SVH
`define RASTER_SETTINGS_SVH

// Signed vertex coordinate width
`define COORD_W 12

// Signed edge value and doubled area width
`define EDGE_W 26

// Reciprocal of the area, unsigned fixed point
`define RECIP_FRAC 23
`define RECIP_W 24

// Inclusive screen bounds in pixels
`define SCREEN_MIN_X 0
`define SCREEN_MAX_X 319
`define SCREEN_MIN_Y 0
`define SCREEN_MAX_Y 239

`define QUEUE_DEPTH 4

`endif

// File: hdl/tri_bbox.sv
`include "raster_settings.svh"

module tri_bbox (
    input  raster_pkg::triangle_t i_tri,
    output raster_pkg::bbox_t     o_box,
    output logic                  o_on_screen
);

    localparam logic signed [`COORD_W-1:0] MIN_X = `COORD_W'(`SCREEN_MIN_X);
    localparam logic signed [`COORD_W-1:0] MAX_X = `COORD_W'(`SCREEN_MAX_X);
    localparam logic signed [`COORD_W-1:0] MIN_Y = `COORD_W'(`SCREEN_MIN_Y);
    localparam logic signed [`COORD_W-1:0] MAX_Y = `COORD_W'(`SCREEN_MAX_Y);

    logic signed [`COORD_W-1:0] raw_min_x;
    logic signed [`COORD_W-1:0] raw_max_x;
    logic signed [`COORD_W-1:0] raw_min_y;
    logic signed [`COORD_W-1:0] raw_max_y;

    function automatic logic signed [`COORD_W-1:0] min3(
        input logic signed [`COORD_W-1:0] a,
        input logic signed [`COORD_W-1:0] b,
        input logic signed [`COORD_W-1:0] c
    );
        logic signed [`COORD_W-1:0] m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic logic signed [`COORD_W-1:0] max3(
        input logic signed [`COORD_W-1:0] a,
        input logic signed [`COORD_W-1:0] b,
        input logic signed [`COORD_W-1:0] c
    );
        logic signed [`COORD_W-1:0] m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    always_comb begin
        raw_min_x = min3(i_tri.v0.x, i_tri.v1.x, i_tri.v2.x);
        raw_max_x = max3(i_tri.v0.x, i_tri.v1.x, i_tri.v2.x);
        raw_min_y = min3(i_tri.v0.y, i_tri.v1.y, i_tri.v2.y);
        raw_max_y = max3(i_tri.v0.y, i_tri.v1.y, i_tri.v2.y);

        // Clamp to the screen
        o_box.min_x = (raw_min_x < MIN_X) ? MIN_X : raw_min_x;
        o_box.max_x = (raw_max_x > MAX_X) ? MAX_X : raw_max_x;
        o_box.min_y = (raw_min_y < MIN_Y) ? MIN_Y : raw_min_y;
        o_box.max_y = (raw_max_y > MAX_Y) ? MAX_Y : raw_max_y;

        // Overlap test uses the unclamped box
        o_on_screen = (raw_max_x >= MIN_X) && (raw_min_x <= MAX_X) &&
                      (raw_max_y >= MIN_Y) && (raw_min_y <= MAX_Y);
    end

endmodule

// File: hdl/tri_queue.sv
`include "raster_settings.svh"

module tri_queue (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  i_valid,
    output logic                  o_ready,
    input  raster_pkg::triangle_t i_tri,
    output logic                  o_valid,
    input  logic                  i_ready,
    output raster_pkg::triangle_t o_tri
);

    localparam int DEPTH = `QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    raster_pkg::triangle_t mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign o_ready = (count != CNT_W'(DEPTH));
    assign o_valid = (count != '0);
    assign o_tri   = mem[rd_ptr];
    assign push    = i_valid && o_ready;
    assign pop     = o_valid && i_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= i_tri;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            // Simultaneous push and pop leaves the count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!rstn) count <= CNT_W'(DEPTH));

endmodule

// File: hdl/tri_setup.sv
`include "raster_settings.svh"

module tri_setup (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  i_valid,
    output logic                  o_ready,
    input  raster_pkg::triangle_t i_tri,
    output logic                  o_valid,
    input  logic                  i_ready,
    output raster_pkg::setup_t    o_setup
);

    typedef enum logic [2:0] {
        IDLE,
        STAGE1,
        CULL,
        DIVIDE,
        DONE
    } state_t;

    state_t state;
    state_t state_next;

    raster_pkg::triangle_t     r_tri;
    raster_pkg::bbox_t         w_box;
    logic                      w_on_screen;
    raster_pkg::bbox_t         r_box;
    logic                      r_on_screen;
    raster_pkg::edge_t         r_e0;
    raster_pkg::edge_t         r_e1;
    raster_pkg::edge_t         r_e2;
    logic signed [`EDGE_W-1:0] r_area;
    logic                      cull;
    logic                      div_start;
    logic                      div_busy;
    logic                      div_done;
    logic [`RECIP_W-1:0]       div_recip;

    // Edge function of a->b evaluated at (px, py)
    function automatic logic signed [`EDGE_W-1:0] edge_value(
        input raster_pkg::vertex_t        a,
        input raster_pkg::vertex_t        b,
        input logic signed [`COORD_W-1:0] px,
        input logic signed [`COORD_W-1:0] py
    );
        logic signed [`EDGE_W-1:0] ab_x;
        logic signed [`EDGE_W-1:0] ab_y;
        logic signed [`EDGE_W-1:0] ap_x;
        logic signed [`EDGE_W-1:0] ap_y;
        ab_x = b.x - a.x;
        ab_y = b.y - a.y;
        ap_x = px - a.x;
        ap_y = py - a.y;
        return ap_x * ab_y - ap_y * ab_x;
    endfunction

    function automatic raster_pkg::edge_t make_edge(
        input raster_pkg::vertex_t        a,
        input raster_pkg::vertex_t        b,
        input logic signed [`COORD_W-1:0] px,
        input logic signed [`COORD_W-1:0] py
    );
        raster_pkg::edge_t e;
        e.value = edge_value(a, b, px, py);
        e.dx    = b.y - a.y;
        e.dy    = a.x - b.x;
        return e;
    endfunction

    tri_bbox tri_bbox_inst (
        .i_tri       (r_tri),
        .o_box       (w_box),
        .o_on_screen (w_on_screen)
    );

    area_reciprocal area_reciprocal_inst (
        .clk     (clk),
        .rstn    (rstn),
        .i_start (div_start),
        .i_area  (r_area),
        .o_busy  (div_busy),
        .o_done  (div_done),
        .o_recip (div_recip)
    );

    // Back-facing, degenerate or off-screen
    assign cull      = (r_area <= 0) || !r_on_screen;
    assign div_start = (state == CULL) && !cull;
    assign o_ready   = (state == IDLE);
    assign o_valid   = (state == DONE);

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (i_valid) begin
                    state_next = STAGE1;
                end
            end
            STAGE1: begin
                state_next = CULL;
            end
            CULL: begin
                state_next = cull ? IDLE : DIVIDE;
            end
            DIVIDE: begin
                if (div_done) begin
                    state_next = DONE;
                end
            end
            DONE: begin
                if (i_ready) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (o_ready && i_valid) begin
            r_tri <= i_tri;
        end

        // Edges sampled at the clamped top-left corner
        if (state == STAGE1) begin
            r_box       <= w_box;
            r_on_screen <= w_on_screen;
            r_e0        <= make_edge(r_tri.v0, r_tri.v1, w_box.min_x, w_box.min_y);
            r_e1        <= make_edge(r_tri.v1, r_tri.v2, w_box.min_x, w_box.min_y);
            r_e2        <= make_edge(r_tri.v2, r_tri.v0, w_box.min_x, w_box.min_y);
            r_area      <= edge_value(r_tri.v0, r_tri.v1, r_tri.v2.x, r_tri.v2.y);
        end

        if ((state == DIVIDE) && div_done) begin
            o_setup.box      <= r_box;
            o_setup.e0       <= r_e0;
            o_setup.e1       <= r_e1;
            o_setup.e2       <= r_e2;
            o_setup.area     <= r_area;
            o_setup.area_inv <= div_recip;
        end
    end

    // Result held under back-pressure
    assert property (@(posedge clk) disable iff (!rstn)
        o_valid && !i_ready |=> o_valid && $stable(o_setup));

    // Divider stays busy until it reports done
    assert property (@(posedge clk) disable iff (!rstn)
        (state == DIVIDE) |-> div_busy || div_done);

endmodule

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f compile.f --top-module tb_raster_frontend || exit 1
out=$(./obj_dir/Vtb_raster_frontend)
echo "$out"
echo "$out" | grep -qF "*** PASSED ***" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// File: test/tb_raster_frontend.sv
`include "raster_settings.svh"

module tb_raster_frontend;

    localparam int N_DIRECTED   = 12;
    localparam int N_BURST      = 8;
    localparam int N_RANDOM     = 300;
    localparam int BURST_START  = N_DIRECTED;
    localparam int RAND_START   = N_DIRECTED + N_BURST;
    localparam int STALL_CYCLES = 60;

    logic                  clk;
    logic                  rstn;
    logic                  i_tri_valid;
    logic                  o_tri_ready;
    raster_pkg::triangle_t i_tri;
    logic                  o_setup_valid;
    logic                  i_setup_ready;
    raster_pkg::setup_t    o_setup;

    raster_pkg::triangle_t stim_q[$];
    raster_pkg::setup_t    exp_q[$];
    raster_pkg::setup_t    ref_setup;
    raster_pkg::setup_t    want;
    raster_pkg::setup_t    held;
    logic                  ref_keep;
    logic                  stalled;
    logic                  saw_full;
    logic [31:0]           lfsr;
    int                    errors;
    int                    accepted;
    int                    results;
    int                    next_idx;
    int                    stall_left;

    raster_frontend raster_frontend_inst (.*);

    always #20 clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Coordinate in -64 .. 383
    function automatic int rand_coord();
        return int'(rand_bits(9) % 32'd448) - 64;
    endfunction

    function automatic raster_pkg::triangle_t make_tri(
        input int x0, input int y0, input int x1, input int y1, input int x2, input int y2
    );
        return {`COORD_W'(x0), `COORD_W'(y0), `COORD_W'(x1), `COORD_W'(y1),
                `COORD_W'(x2), `COORD_W'(y2)};
    endfunction

    function automatic raster_pkg::edge_t edge_at(
        input int ax, input int ay, input int bx, input int by, input int px, input int py
    );
        raster_pkg::edge_t e;
        e.value = `EDGE_W'((px - ax) * (by - ay) - (py - ay) * (bx - ax));
        e.dx    = `EDGE_W'(by - ay);
        e.dy    = `EDGE_W'(-(bx - ax));
        return e;
    endfunction

    // Expected setup result, keep is low for a culled triangle
    function automatic raster_pkg::setup_t expect_setup(
        input  raster_pkg::triangle_t t,
        output logic                  keep
    );
        raster_pkg::setup_t s;
        int                 p[3][2];
        int                 lo[2];
        int                 hi[2];
        int                 area;
        int                 a;
        int                 k;
        logic               on_screen;
        p[0] = '{int'(t.v0.x), int'(t.v0.y)};
        p[1] = '{int'(t.v1.x), int'(t.v1.y)};
        p[2] = '{int'(t.v2.x), int'(t.v2.y)};
        for (a = 0; a < 2; a++) begin
            lo[a] = p[0][a];
            hi[a] = p[0][a];
            for (k = 1; k < 3; k++) begin
                lo[a] = (p[k][a] < lo[a]) ? p[k][a] : lo[a];
                hi[a] = (p[k][a] > hi[a]) ? p[k][a] : hi[a];
            end
        end
        on_screen = (hi[0] >= `SCREEN_MIN_X) && (lo[0] <= `SCREEN_MAX_X) &&
                    (hi[1] >= `SCREEN_MIN_Y) && (lo[1] <= `SCREEN_MAX_Y);
        lo[0] = (lo[0] < `SCREEN_MIN_X) ? `SCREEN_MIN_X : lo[0];
        lo[1] = (lo[1] < `SCREEN_MIN_Y) ? `SCREEN_MIN_Y : lo[1];
        hi[0] = (hi[0] > `SCREEN_MAX_X) ? `SCREEN_MAX_X : hi[0];
        hi[1] = (hi[1] > `SCREEN_MAX_Y) ? `SCREEN_MAX_Y : hi[1];
        s.box = {`COORD_W'(lo[0]), `COORD_W'(lo[1]), `COORD_W'(hi[0]), `COORD_W'(hi[1])};
        // Edges sampled at the clamped top-left corner
        s.e0 = edge_at(p[0][0], p[0][1], p[1][0], p[1][1], lo[0], lo[1]);
        s.e1 = edge_at(p[1][0], p[1][1], p[2][0], p[2][1], lo[0], lo[1]);
        s.e2 = edge_at(p[2][0], p[2][1], p[0][0], p[0][1], lo[0], lo[1]);
        area = (p[2][0] - p[0][0]) * (p[1][1] - p[0][1]) - (p[2][1] - p[0][1]) * (p[1][0] - p[0][0]);
        s.area = `EDGE_W'(area);
        keep = on_screen && (area > 0);
        s.area_inv = '0;
        if (keep) begin
            s.area_inv = `RECIP_W'((1 << `RECIP_FRAC) / area);
        end
        return s;
    endfunction

    task automatic build_stimulus();
        int n;
        stim_q.push_back(make_tri(10, 10, 10, 40, 50, 10));
        stim_q.push_back(make_tri(100, 50, 120, 200, 300, 60));
        stim_q.push_back(make_tri(5, 5, 5, 6, 6, 5));
        // Crossing the screen edges
        stim_q.push_back(make_tri(-30, -20, -30, 100, 80, -20));
        stim_q.push_back(make_tri(250, 180, 250, 300, 370, 180));
        stim_q.push_back(make_tri(-60, -60, -60, 380, 380, -60));
        // Clockwise, collinear, repeated vertex, then two off screen
        stim_q.push_back(make_tri(10, 10, 50, 10, 10, 40));
        stim_q.push_back(make_tri(0, 0, 10, 10, 20, 20));
        stim_q.push_back(make_tri(30, 30, 30, 30, 60, 90));
        stim_q.push_back(make_tri(-60, 10, -60, 50, -20, 10));
        stim_q.push_back(make_tri(100, 250, 100, 300, 150, 250));
        stim_q.push_back(make_tri(200, 20, 200, 90, 260, 20));
        for (n = 0; n < N_BURST; n++) begin
            stim_q.push_back(make_tri(20 + 10 * n, 30, 20 + 10 * n, 80, 60 + 10 * n, 30));
        end
        for (n = 0; n < N_RANDOM; n++) begin
            stim_q.push_back(make_tri(rand_coord(), rand_coord(), rand_coord(),
                                      rand_coord(), rand_coord(), rand_coord()));
        end
    endtask

    task automatic report_mismatch(input string field);
        $display("[FAIL] t=%0t %s does not match the expected value", $time, field);
        errors++;
    endtask

    initial begin
        clk           = 1'b0;
        rstn          = 1'b0;
        i_tri_valid   = 1'b0;
        i_tri         = '0;
        i_setup_ready = 1'b0;
        lfsr          = 32'h9c03_184a;
        errors        = 0;
        accepted      = 0;
        next_idx      = 0;
        stall_left    = 0;
        saw_full      = 1'b0;
        build_stimulus();
        repeat (8) @(posedge clk);
        if (o_setup_valid !== 1'b0) begin
            $display("[FAIL] t=%0t o_setup_valid is not low after reset", $time);
            errors++;
        end
        if (o_tri_ready !== 1'b1) begin
            $display("[FAIL] t=%0t o_tri_ready is not high after reset", $time);
            errors++;
        end
        rstn <= 1'b1;

        while (next_idx < stim_q.size()) begin
            @(posedge clk);
            if (i_tri_valid && o_tri_ready) begin
                ref_setup = expect_setup(i_tri, ref_keep);
                if (ref_keep) begin
                    exp_q.push_back(ref_setup);
                end
                accepted++;
                next_idx++;
                if (next_idx == BURST_START) begin
                    stall_left = STALL_CYCLES;
                end
            end
            if (stall_left > 0) begin
                if (!o_tri_ready) begin
                    saw_full = 1'b1;
                end
                stall_left--;
            end
            // A pending triangle stays on the port until the queue takes it
            if (!i_tri_valid || o_tri_ready) begin
                if ((next_idx < stim_q.size()) &&
                    ((next_idx < RAND_START) || (rand_bits(2) != 0))) begin
                    i_tri_valid <= 1'b1;
                    i_tri       <= stim_q[next_idx];
                end else begin
                    i_tri_valid <= 1'b0;
                end
            end
            if (stall_left > 0) begin
                i_setup_ready <= 1'b0;
            end else if (next_idx < RAND_START) begin
                i_setup_ready <= 1'b1;
            end else begin
                i_setup_ready <= (rand_bits(1) != 0);
            end
        end

        while (exp_q.size() != 0) begin
            @(posedge clk);
            i_setup_ready <= (rand_bits(1) != 0);
        end
        i_setup_ready <= 1'b1;
        repeat (40) @(posedge clk);

        if (!saw_full) begin
            $display("The input ready never fell while the output was stalled");
            errors++;
        end
        $display("Triangles accepted %0d, results checked %0d, errors %0d",
                 accepted, results, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        stalled = 1'b0;
        results = 0;
        forever begin
            @(posedge clk);
            if (rstn) begin
                if (stalled && (!o_setup_valid || (o_setup !== held))) begin
                    $display("[FAIL] t=%0t o_setup changed while the output was stalled", $time);
                    errors++;
                end
                stalled = 1'b0;
                if (o_setup_valid && i_setup_ready) begin
                    if (exp_q.size() == 0) begin
                        $display("Unexpected result at time %0t with no triangle waiting", $time);
                        errors++;
                    end else begin
                        want = exp_q.pop_front();
                        results++;
                        if (o_setup.box !== want.box) report_mismatch("box");
                        if (o_setup.e0 !== want.e0) report_mismatch("e0");
                        if (o_setup.e1 !== want.e1) report_mismatch("e1");
                        if (o_setup.e2 !== want.e2) report_mismatch("e2");
                        if (o_setup.area !== want.area) report_mismatch("area");
                        if (o_setup.area_inv !== want.area_inv) report_mismatch("area_inv");
                    end
                end else if (o_setup_valid) begin
                    stalled = 1'b1;
                    held    = o_setup;
                end
            end
        end
    end

    // Budget of 400 triangles at the full divide latency plus margin
    initial begin
        #(400 * (`RECIP_W + 10) * 40);
        $display("Timeout: the run did not finish in the time allowed");
        $display("*** FAILED ***");
        $finish;
    end

endmodule
